// ==== verilog/eeprom_settings.svh ====
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// clk cycles per half scl period, 2 or more
// sda moves one cycle after each scl edge, hence the lower bound
`define EE_SCL_HALF 4

// 24C16 array, 2 Kbyte
`define EE_ADDR_W 11

// device code ahead of the block select bits
`define EE_DEV_CODE 4'b1010

`endif

// ==== verilog/eeprom_pkg.sv ====
`include "eeprom_settings.svh"

package eeprom_pkg;

    // host request, write data ignored on reads
    typedef struct packed {
        logic                  write;
        logic [`EE_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;  // zero for writes
        logic       nack;   // some sent byte went unacknowledged
    } eeprom_rsp_t;

    // OP_START doubles as repeated start
    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } i2c_op_t;

    typedef struct packed {
        i2c_op_t    op;
        logic [7:0] data;   // byte to shift out
        logic       ack;    // master ack bit after a read, 1 is nack
    } i2c_cmd_t;

    typedef struct packed {
        logic [7:0] data;   // byte shifted in
        logic       nack;   // ack bit sampled after a write
    } i2c_res_t;

endpackage

// ==== verilog/i2c_bit_engine.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::i2c_cmd_t cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    output eeprom_pkg::i2c_res_t res,
    output logic                 res_valid,
    output logic                 scl,
    output logic                 sda_drive_low,
    input  logic                 sda_in
);
    import eeprom_pkg::*;

    localparam int HALF  = `EE_SCL_HALF;
    localparam int CNT_W = $clog2(HALF);

    logic             busy;
    i2c_op_t          op_q;
    logic             ack_q;
    logic [7:0]       shreg;
    logic [3:0]       bit_cnt;
    logic             half;     // 0 scl low, 1 scl high
    logic [CNT_W-1:0] cnt;

    logic             byte_op;
    logic             half_end;
    logic             last_bit;
    logic             drive_pt;

    assign cmd_ready = !busy;
    assign byte_op   = (op_q == OP_WRITE) || (op_q == OP_READ);
    assign half_end  = (cnt == CNT_W'(HALF - 1));
    assign last_bit  = byte_op ? (bit_cnt == 4'd8) : (bit_cnt == 4'd0);
    assign drive_pt  = busy && (cnt == '0);  // one cycle after an scl edge

    // scl holds its level between commands, so no stray pulses
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy          <= 1'b0;
            res_valid     <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            half          <= 1'b0;
            cnt           <= '0;
            bit_cnt       <= 4'd0;
        end
        else
        begin
            res_valid <= 1'b0;
            if (!busy)
            begin
                if (cmd_valid)
                begin
                    busy    <= 1'b1;
                    half    <= 1'b0;
                    cnt     <= '0;
                    bit_cnt <= 4'd0;
                    scl     <= 1'b0;
                end
            end
            else
            begin
                if (drive_pt)
                begin
                    if (!half)
                    begin
                        case (op_q)
                            OP_START: sda_drive_low <= 1'b0;
                            OP_STOP:  sda_drive_low <= 1'b1;
                            OP_WRITE: sda_drive_low <= bit_cnt[3] ? 1'b0 : !shreg[7];
                            default:  sda_drive_low <= bit_cnt[3] ? !ack_q : 1'b0;
                        endcase
                    end
                    else if (op_q == OP_START)
                        sda_drive_low <= 1'b1;  // falling sda with scl high
                    else if (op_q == OP_STOP)
                        sda_drive_low <= 1'b0;  // rising sda with scl high
                end

                if (half_end)
                begin
                    cnt <= '0;
                    if (!half)
                    begin
                        half <= 1'b1;
                        scl  <= 1'b1;
                    end
                    else if (last_bit)
                    begin
                        busy      <= 1'b0;
                        res_valid <= 1'b1;
                        half      <= 1'b0;
                        bit_cnt   <= 4'd0;
                    end
                    else
                    begin
                        half    <= 1'b0;
                        scl     <= 1'b0;
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && cmd_valid)
        begin
            op_q  <= cmd.op;
            ack_q <= cmd.ack;
            shreg <= cmd.data;
        end
        else if (busy)
        begin
            if (drive_pt && !half && op_q == OP_WRITE && !bit_cnt[3])
                shreg <= {shreg[6:0], 1'b0};  // msb first
            if (half && half_end && op_q == OP_READ && !bit_cnt[3])
                shreg <= {shreg[6:0], sda_in};  // sampled at end of scl high
            if (half && half_end && last_bit)
            begin
                res.data <= shreg;
                res.nack <= (op_q == OP_WRITE) && sda_in;
            end
        end
    end

    // data bits of a write must not move under a high scl
    a_write_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (busy && op_q == OP_WRITE && scl && $past(scl)) |-> $stable(sda_drive_low));

endmodule

// ==== verilog/eeprom_sequencer.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_sequencer
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::eeprom_req_t req,
    input  logic                    req_valid,
    output logic                    req_ready,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output eeprom_pkg::i2c_cmd_t    cmd,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    input  eeprom_pkg::i2c_res_t    res,
    input  logic                    res_valid
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA,
        RESTART,
        CTRL_R,
        READ,
        STOP,
        RESP
    } state_t;

    state_t      state;
    state_t      state_nxt;
    eeprom_req_t req_q;
    logic [7:0]  rdata_q;
    logic        nack_q;
    logic        accept;
    logic        launch;
    logic        sent_byte;

    // bus command issued on entry to each state
    function automatic i2c_cmd_t cmd_for(state_t st, eeprom_req_t r);
        i2c_cmd_t              c;
        logic [`EE_ADDR_W-9:0] block;
        block  = r.addr[`EE_ADDR_W-1:8];
        c.op   = OP_WRITE;
        c.ack  = 1'b1;  // single byte read ends with master nack
        c.data = {`EE_DEV_CODE, block, 1'b0};
        case (st)
            START, RESTART: c.op = OP_START;
            STOP:           c.op = OP_STOP;
            CTRL_R:         c.data = {`EE_DEV_CODE, block, 1'b1};
            ADDR:           c.data = r.addr[7:0];
            DATA:           c.data = r.wdata;
            READ:           c.op = OP_READ;
            default:        ;
        endcase
        return c;
    endfunction

    assign req_ready = (state == IDLE);
    assign rsp_valid = (state == RESP);
    assign rsp       = '{rdata: rdata_q, nack: nack_q};
    assign accept    = req_valid && req_ready;
    assign sent_byte = (state == CTRL_W) || (state == ADDR) ||
                       (state == DATA) || (state == CTRL_R);
    assign launch    = (state_nxt != state) && (state_nxt != IDLE) && (state_nxt != RESP);

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:    if (accept) state_nxt = START;
            START:   if (res_valid) state_nxt = CTRL_W;
            CTRL_W:  if (res_valid) state_nxt = res.nack ? STOP : ADDR;
            ADDR:    if (res_valid) state_nxt = res.nack ? STOP : (req_q.write ? DATA : RESTART);
            DATA:    if (res_valid) state_nxt = STOP;
            RESTART: if (res_valid) state_nxt = CTRL_R;
            CTRL_R:  if (res_valid) state_nxt = res.nack ? STOP : READ;
            READ:    if (res_valid) state_nxt = STOP;
            STOP:    if (res_valid) state_nxt = RESP;
            RESP:    if (rsp_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            cmd_valid <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (launch)
                cmd_valid <= 1'b1;
            else if (cmd_ready)
                cmd_valid <= 1'b0;  // taken by the engine
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_q   <= req;
            nack_q  <= 1'b0;
            rdata_q <= 8'h00;
        end
        else if (res_valid)
        begin
            if (sent_byte)
                nack_q <= nack_q | res.nack;
            if (state == READ)
                rdata_q <= res.data;
        end
        if (launch)
            cmd <= cmd_for(state_nxt, req_q);  // start needs no request fields
    end

    // response held steady under back-pressure
    a_rsp_hold: assert property (@(posedge CLK) disable iff (RESET)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)));

    a_no_cmd_idle: assert property (@(posedge CLK) disable iff (RESET)
        (state == IDLE) |-> !cmd_valid);

endmodule

// ==== verilog/eeprom_ctrl_top.sv ====
`timescale 1ns/100ps

module eeprom_ctrl_top
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::eeprom_req_t req,
    input  logic                    req_valid,
    output logic                    req_ready,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic                    scl,
    output logic                    sda_drive_low,
    input  logic                    sda_in
);
    import eeprom_pkg::*;

    i2c_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    i2c_res_t res;
    logic     res_valid;

    eeprom_sequencer i_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .res       (res),
        .res_valid (res_valid)
    );

    // sda is open drain, wired-AND outside
    i2c_bit_engine i_bit
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .res           (res),
        .res_valid     (res_valid),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

// ==== verification/eeprom_model.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_model
(
    input  logic scl,
    input  logic sda,
    input  logic nack_knob,     // refuse the next control byte
    output logic sda_drive_low,
    output int   error_count
);
    localparam int P_NONE = 0;
    localparam int P_CTRL = 1;
    localparam int P_ADDR = 2;
    localparam int P_DATA = 3;
    localparam int P_READ = 4;

    logic [7:0]            mem [0:2047];
    logic [`EE_ADDR_W-1:0] ptr;
    logic [7:0]            sh;
    logic [7:0]            rbyte;
    int                    bit_cnt;  // scl rises since byte start
    int                    phase;
    logic                  active;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ {i[10:8], 5'b0} ^ 8'h5a;
        sda_drive_low = 1'b0;
        error_count   = 0;
        active        = 1'b0;
        bit_cnt       = 0;
        phase         = P_NONE;
        ptr           = '0;
        sh            = 8'h00;
        rbyte         = 8'h00;
    end

    // start and stop may only follow the first scl rise of a byte slot
    always @(sda)
    begin
        if (scl === 1'b1)
        begin
            if (active && bit_cnt != 1)
            begin
                error_count++;
                $display("protocol error: SDA changed while SCL was high inside a byte at %0t",
                         $time);
            end
            if (sda === 1'b0)
            begin
                active  = 1'b1;  // start or repeated start
                bit_cnt = 0;
                phase   = P_CTRL;
            end
            else if (sda === 1'b1)
            begin
                active  = 1'b0;  // stop
                bit_cnt = 0;
                phase   = P_NONE;
            end
        end
    end

    always @(posedge scl)
    begin
        if (active && bit_cnt < 9)
        begin
            if (bit_cnt < 8)
                sh = {sh[6:0], sda};
            bit_cnt++;
        end
    end

    always @(negedge scl)
    begin
        if (!active)
            sda_drive_low = 1'b0;
        else if (bit_cnt == 9)
        begin
            bit_cnt       = 0;
            sda_drive_low = (phase == P_READ) ? !rbyte[7] : 1'b0;
        end
        else if (bit_cnt == 8)
        begin
            case (phase)
                P_CTRL:
                begin
                    if (nack_knob || sh[7:4] != `EE_DEV_CODE)
                    begin
                        sda_drive_low = 1'b0;
                        phase         = P_NONE;
                    end
                    else
                    begin
                        sda_drive_low = 1'b1;
                        ptr[10:8]     = sh[3:1];  // block select
                        if (sh[0])
                        begin
                            phase = P_READ;
                            rbyte = mem[ptr];
                        end
                        else
                            phase = P_ADDR;
                    end
                end
                P_ADDR:
                begin
                    sda_drive_low = 1'b1;
                    ptr[7:0]      = sh;
                    phase         = P_DATA;
                end
                P_DATA:
                begin
                    sda_drive_low = 1'b1;
                    mem[ptr]      = sh;
                    phase         = P_NONE;
                end
                default:
                begin
                    sda_drive_low = 1'b0;  // master ack slot after read
                    phase         = P_NONE;
                end
            endcase
        end
        else if (phase == P_READ && bit_cnt > 0)
            sda_drive_low = !rbyte[7 - bit_cnt];
    end

endmodule

// ==== verification/eeprom_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_ctrl_tb;
    import eeprom_pkg::*;

    localparam int NUM_TXN  = 66;
    localparam int LIMIT_NS = NUM_TXN * 70 * 2 * `EE_SCL_HALF * 100 + 200000;

    logic        CLK = 1'b0;
    logic        RESET = 1'b1;
    eeprom_req_t req;
    logic        req_valid;
    logic        req_ready;
    eeprom_rsp_t rsp;
    logic        rsp_valid;
    logic        rsp_ready;
    logic        scl;
    logic        sda_drive_low;
    logic        mem_drive_low;
    logic        nack_knob;
    wire         sda;
    int          proto_errors;
    int          errors = 0;
    logic [7:0]  ref_mem [0:2047];

    assign sda = !sda_drive_low && !mem_drive_low;  // wired-AND bus

    always #50 CLK = !CLK;

    eeprom_ctrl_top i_dut
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

    eeprom_model i_mem
    (
        .scl           (scl),
        .sda           (sda),
        .nack_knob     (nack_knob),
        .sda_drive_low (mem_drive_low),
        .error_count   (proto_errors)
    );

    task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic run_txn(input string name, input logic wr, input logic [10:0] addr,
                           input logic [7:0] wdata, input logic nack_exp);
        eeprom_rsp_t got;
        logic [7:0]  exp_data;
        int          delay;
        exp_data = (wr || nack_exp) ? 8'h00 : ref_mem[addr];
        @(posedge CLK);
        #1;
        req       = '{write: wr, addr: addr, wdata: wdata};
        req_valid = 1'b1;
        @(negedge CLK);
        while (!req_ready)
            @(negedge CLK);
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
        @(negedge CLK);
        while (!rsp_valid)
        begin
            if (req_ready)
            begin
                errors++;
                $display("request channel ready before the response was taken in %s", name);
            end
            @(negedge CLK);
        end
        got   = rsp;
        delay = $urandom_range(0, 6);
        if (req_ready)
        begin
            errors++;
            $display("request channel ready while the response was pending in %s", name);
        end
        repeat (delay)
        begin
            @(negedge CLK);
            if (!rsp_valid || rsp !== got)
            begin
                errors++;
                $display("response changed while held back in %s", name);
            end
            if (req_ready)
            begin
                errors++;
                $display("request channel ready while the response was held back in %s",
                         name);
            end
        end
        @(posedge CLK);
        #1;
        rsp_ready = 1'b1;
        @(posedge CLK);
        #1;
        rsp_ready = 1'b0;
        check({name, " rdata"}, exp_data, got.rdata);
        check({name, " nack"}, {7'b0, nack_exp}, {7'b0, got.nack});
        if (wr && !nack_exp)
            ref_mem[addr] = wdata;
    endtask

    initial
    begin
        logic [31:0] r;
        logic [10:0] addr;
        logic [7:0]  data;
        void'($urandom(32'h941c));
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        nack_knob = 1'b0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = i[7:0] ^ {i[10:8], 5'b0} ^ 8'h5a;
        repeat (3) @(posedge CLK);
        #1 RESET = 1'b0;

        r = $urandom;
        run_txn("untouched read", 1'b0, r[10:0], 8'h00, 1'b0);
        r = $urandom;
        addr = r[10:0];
        data = r[23:16];
        run_txn("write", 1'b1, addr, data, 1'b0);
        run_txn("read back", 1'b0, addr, 8'h00, 1'b0);

        for (int n = 0; n < 60; n++)
        begin
            r = $urandom;
            run_txn("mixed", r[31], r[10:0], r[23:16], 1'b0);
        end

        r = $urandom;
        addr = r[10:0];
        data = ~ref_mem[addr];  // differs from the stored value
        nack_knob = 1'b1;
        run_txn("nacked write", 1'b1, addr, data, 1'b1);
        run_txn("nacked read", 1'b0, addr, 8'h00, 1'b1);
        nack_knob = 1'b0;
        run_txn("read after nack", 1'b0, addr, 8'h00, 1'b0);

        repeat (4) @(posedge CLK);
        $display("errors: %0d check, %0d protocol", errors, proto_errors);
        if (errors == 0 && proto_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        #(LIMIT_NS);
        $display("watchdog timeout: the controller did not finish its transactions in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== eeprom_ctrl_top.f ====
+incdir+verilog
verilog/eeprom_pkg.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_ctrl_top.sv
verification/eeprom_model.sv
verification/eeprom_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f eeprom_ctrl_top.f \
    --top-module eeprom_ctrl_tb -o eeprom_sim \
    && ./obj_dir/eeprom_sim > sim.log 2>&1 \
    || { echo "build or run error"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; } \
    || echo "simulation passed"
